//--- files.f
kbd_pkg.sv
kbd_byte_if.sv
video_if.sv
ps2_receiver.sv
key_tracker.sv
vga_timing.sv
glyph_renderer.sv
seg_display.sv
kbd_display_top.sv
tb_kbd_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the keyboard display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_kbd_display -o tb_kbd_display
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/tb_kbd_display)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb_kbd_display.sv
`timescale 1ns/1ps

module tb_kbd_display import kbd_pkg::*; ();

	logic       clk = 1'b0;
	logic       rst;
	logic       ps2_clk;
	logic       ps2_data;
	logic       vga_hsync;
	logic       vga_vsync;
	logic       vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic [7:0] seg0;
	logic [7:0] seg1;
	logic [7:0] seg4;
	logic [7:0] seg5;
	logic [7:0] ledr;

	integer     seed;

	// reference model state
	scan_t      exp_code;
	logic       exp_held;
	logic [7:0] exp_releases;
	logic       exp_pending;
	logic       exp_frame_err;

	// reference artwork for the two glyphs, bit 7 leftmost
	localparam logic [7:0] REF_Q [16] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h76, 8'hcc, 8'hcc,
		8'hcc, 8'hcc, 8'hcc, 8'h7c, 8'h0c, 8'h0c, 8'h1e, 8'h00
	};
	localparam logic [7:0] REF_D [16] = '{
		8'h00, 8'h00, 8'h1c, 8'h0c, 8'h0c, 8'h3c, 8'h6c, 8'hcc,
		8'hcc, 8'hcc, 8'hcc, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00
	};

	kbd_display_top #(
		.H_ACTIVE (32),
		.H_FP     (2),
		.H_SYNC   (4),
		.H_BP     (2),
		.V_ACTIVE (20),
		.V_FP     (1),
		.V_SYNC   (2),
		.V_BP     (1)
	) kbd_display_top_inst (
		.clk         (clk),
		.rst         (rst),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.vga_hsync   (vga_hsync),
		.vga_vsync   (vga_vsync),
		.vga_blank_n (vga_blank_n),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.seg0        (seg0),
		.seg1        (seg1),
		.seg4        (seg4),
		.seg5        (seg5),
		.ledr        (ledr)
	);

	always #10 clk = ~clk;

	// segments a..g then dp, active high
	function automatic logic [7:0] hex_to_seg(logic [3:0] hex);
		case (hex)
			4'h0: return 8'hfc;
			4'h1: return 8'h60;
			4'h2: return 8'hda;
			4'h3: return 8'hf2;
			4'h4: return 8'h66;
			4'h5: return 8'hb6;
			4'h6: return 8'hbe;
			4'h7: return 8'he0;
			4'h8: return 8'hfe;
			4'h9: return 8'hf6;
			4'ha: return 8'hee;
			4'hb: return 8'h3e;
			4'hc: return 8'h9c;
			4'hd: return 8'h7a;
			4'he: return 8'h9e;
			default: return 8'h8e;
		endcase
	endfunction

	function automatic int glyph_pixels(scan_t code);
		int         total;
		logic [7:0] row;
		total = 0;
		for (int r = 0; r < 16; r++) begin
			row = (code == SC_Q) ? REF_Q[r] : (code == SC_D) ? REF_D[r] : 8'h00;
			total += $countones(row);
		end
		return total;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_code(input string name, input scan_t exp, input scan_t act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_seg(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_rgb(input string name, input logic [23:0] exp, input logic [23:0] act);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_total(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	// one 11-bit frame, lsb first, 16 system cycles per ps2 clock
	task automatic send_frame(input scan_t data, input bit bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			repeat (8) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (8) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic apply_byte(input scan_t b);
		if (b == SC_BREAK) begin
			exp_pending = 1'b1;
		end else if (exp_pending) begin
			exp_pending  = 1'b0;
			exp_held     = 1'b0;
			exp_releases = exp_releases + 8'd1;
		end else begin
			exp_code = b;
			exp_held = 1'b1;
		end
	endtask

	task automatic wait_led(input int idx, input logic val, input string what);
		int n;
		n = 0;
		while (ledr[idx] !== val && n < 5000) begin
			@(negedge clk);
			n++;
		end
		if (ledr[idx] !== val) begin
			$display("timeout after 5000 cycles waiting for %s", what);
			abort_run();
		end
	endtask

	task automatic check_all();
		check_code("last_code", exp_code, kbd_display_top_inst.last_code);
		check_seg("seg0", ~hex_to_seg(exp_code[3:0]), seg0);
		check_seg("seg1", ~hex_to_seg(exp_code[7:4]), seg1);
		check_count("releases", exp_releases, kbd_display_top_inst.releases);
		check_seg("seg4", ~hex_to_seg(exp_releases[3:0]), seg4);
		check_seg("seg5", ~hex_to_seg(exp_releases[7:4]), seg5);
		check_flag("ledr held", exp_held, ledr[7]);
		check_flag("ledr frame_err", exp_frame_err, ledr[6]);
		check_flag("ledr overflow", 1'b0, ledr[5]);
		check_flag("ledr ready", 1'b0, ledr[4]);
		check_count("ledr level", 8'h00, {4'h0, ledr[3:0]});
	endtask

	task automatic deliver_byte(input scan_t b);
		send_frame(b, 1'b0);
		apply_byte(b);
		wait_led(4, 1'b0, "FIFO to drain");
		check_all();
	endtask

	// counts black active pixels and hsync pulses between two vsync falls
	task automatic measure_frame(output int black, output int hsyncs);
		int   n;
		logic vs_prev;
		logic hs_prev;
		n = 0;
		vs_prev = vga_vsync;
		@(negedge clk);
		while (!(vs_prev && !vga_vsync) && n < 5000) begin
			vs_prev = vga_vsync;
			@(negedge clk);
			n++;
		end
		if (!(vs_prev && !vga_vsync)) begin
			$display("timeout after 5000 cycles waiting for vsync");
			abort_run();
		end
		black = 0;
		hsyncs = 0;
		n = 0;
		hs_prev = vga_hsync;
		do begin
			// dark in blanking, otherwise black glyph or white background
			if (!vga_blank_n)
				check_rgb("vga rgb in blanking", 24'h000000, {vga_r, vga_g, vga_b});
			else if ({vga_r, vga_g, vga_b} == 24'h0)
				black++;
			else
				check_rgb("vga rgb background", 24'hffffff, {vga_r, vga_g, vga_b});
			if (hs_prev && !vga_hsync)
				hsyncs++;
			hs_prev = vga_hsync;
			vs_prev = vga_vsync;
			@(negedge clk);
			n++;
		end while (!(vs_prev && !vga_vsync) && n < 5000);
		if (!(vs_prev && !vga_vsync)) begin
			$display("timeout after 5000 cycles measuring a video frame");
			abort_run();
		end
	endtask

	initial begin
		int    sel;
		int    black;
		int    hsyncs;
		scan_t code;
		scan_t glyph_codes [3];

		seed = 27;
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		exp_code = 8'h00;
		exp_held = 1'b0;
		exp_releases = 8'h00;
		exp_pending = 1'b0;
		exp_frame_err = 1'b0;
		glyph_codes = '{SC_Q, SC_D, 8'h1c};

		// reset values, sampled while rst is still high
		repeat (8) @(negedge clk);
		check_all();
		check_flag("vga_hsync", 1'b1, vga_hsync);
		check_flag("vga_vsync", 1'b1, vga_vsync);
		check_flag("vga_blank_n", 1'b0, vga_blank_n);
		rst = 1'b0;

		measure_frame(black, hsyncs);
		check_total("hsync pulses per frame", 24, hsyncs);
		check_total("black pixels for code 00", 0, black);

		// make, break prefix, release
		for (int i = 0; i < 40; i++) begin
			sel = $unsigned($random(seed)) % 3;
			code = (sel == 0) ? SC_Q : (sel == 1) ? SC_D : scan_t'($random(seed));
			if (code == SC_BREAK)
				code = 8'h1c;
			deliver_byte(code);
			deliver_byte(SC_BREAK);
			deliver_byte(code);
		end

		// long run of releases, enough to wrap the counter
		for (int i = 0; i < 260; i++) begin
			deliver_byte(SC_BREAK);
			deliver_byte(SC_Q);
		end

		send_frame(SC_D, 1'b1);
		exp_frame_err = 1'b1;
		wait_led(6, 1'b1, "frame_err after a parity error");
		check_all();
		deliver_byte(SC_D);

		// burst with no idle time between frames
		for (int i = 0; i < 10; i++) begin
			code = scan_t'($random(seed));
			if (code == SC_BREAK)
				code = 8'h2b;
			send_frame(code, 1'b0);
			apply_byte(code);
			check_all();
		end
		wait_led(4, 1'b0, "FIFO to drain after the burst");
		check_all();

		foreach (glyph_codes[g]) begin
			deliver_byte(glyph_codes[g]);
			measure_frame(black, hsyncs);
			check_total("black glyph pixels", glyph_pixels(glyph_codes[g]), black);
			check_total("hsync pulses per frame", 24, hsyncs);
		end

		check_all();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- kbd_display_top.sv
`timescale 1ns/1ps

module kbd_display_top import kbd_pkg::*; #(
	parameter int FIFO_DEPTH  = 8,
	parameter int IDLE_CYCLES = 2000,
	parameter int H_ACTIVE    = 640,
	parameter int H_FP        = 16,
	parameter int H_SYNC      = 96,
	parameter int H_BP        = 48,
	parameter int V_ACTIVE    = 480,
	parameter int V_FP        = 10,
	parameter int V_SYNC      = 2,
	parameter int V_BP        = 33
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic        vga_hsync,
	output logic        vga_vsync,
	output logic        vga_blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic [7:0]  seg0,
	output logic [7:0]  seg1,
	output logic [7:0]  seg4,
	output logic [7:0]  seg5,
	output logic [7:0]  ledr
);

	kbd_byte_if byte_bus ();
	video_if    vid_bus ();

	logic       frame_err;
	logic [3:0] level;
	scan_t      last_code;
	logic       held;
	logic [7:0] releases;

	ps2_receiver #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.IDLE_CYCLES (IDLE_CYCLES)
	) ps2_receiver_inst (
		.clk       (clk),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.bus       (byte_bus.rx),
		.frame_err (frame_err),
		.level     (level)
	);

	key_tracker key_tracker_inst (
		.clk       (clk),
		.rst       (rst),
		.bus       (byte_bus.sink),
		.last_code (last_code),
		.held      (held),
		.releases  (releases)
	);

	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FP     (H_FP),
		.H_SYNC   (H_SYNC),
		.H_BP     (H_BP),
		.V_ACTIVE (V_ACTIVE),
		.V_FP     (V_FP),
		.V_SYNC   (V_SYNC),
		.V_BP     (V_BP)
	) vga_timing_inst (
		.clk     (clk),
		.rst     (rst),
		.vid     (vid_bus.timing),
		.hsync   (vga_hsync),
		.vsync   (vga_vsync),
		.blank_n (vga_blank_n),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b)
	);

	glyph_renderer glyph_renderer_inst (
		.clk  (clk),
		.rst  (rst),
		.vid  (vid_bus.render),
		.code (last_code)
	);

	seg_display seg_display_inst (
		.code  (last_code),
		.count (releases),
		.seg0  (seg0),
		.seg1  (seg1),
		.seg4  (seg4),
		.seg5  (seg5)
	);

	// flags on the upper leds, fifo level on the lower four
	assign ledr = {held, frame_err, byte_bus.overflow, byte_bus.ready, level};

endmodule

//--- seg_display.sv
`timescale 1ns/1ps

module seg_display import kbd_pkg::*; (
	input  scan_t       code,
	input  logic [7:0]  count,
	output logic [7:0]  seg0,
	output logic [7:0]  seg1,
	output logic [7:0]  seg4,
	output logic [7:0]  seg5
);

	// digits are active low, so invert the table pattern
	assign seg0 = ~seg_of_hex(code[3:0]);
	assign seg1 = ~seg_of_hex(code[7:4]);

	// release count on the upper pair
	assign seg4 = ~seg_of_hex(count[3:0]);
	assign seg5 = ~seg_of_hex(count[7:4]);

endmodule

//--- glyph_renderer.sv
`timescale 1ns/1ps

module glyph_renderer import kbd_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	video_if.render vid,
	input  scan_t   code
);

	logic       in_box;
	logic [7:0] row_bits;
	logic [2:0] col;

	// glyph box is the top-left 8x16 cell
	assign in_box = vid.active && (vid.h_addr < 10'd8) && (vid.v_addr < 10'd16);

	assign row_bits = glyph_row(code, vid.v_addr[3:0]);

	// bit 7 is the leftmost column
	assign col = 3'd7 - vid.h_addr[2:0];

	always_ff @(posedge clk) begin
		if (rst)
			vid.pixel_black <= 1'b0;
		else if (in_box)
			vid.pixel_black <= row_bits[col];
		else
			vid.pixel_black <= 1'b0;
	end

endmodule

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FP     = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BP     = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FP     = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BP     = 33
) (
	input  logic        clk,
	input  logic        rst,
	video_if.timing     vid,
	output logic        hsync,
	output logic        vsync,
	output logic        blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b
);

	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic       hsync_raw;
	logic       vsync_raw;
	logic [7:0] level;

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == 10'(H_TOTAL - 1)) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// syncs are active low inside their window
	assign hsync_raw = ~((h_cnt >= 10'(H_ACTIVE + H_FP)) &&
		(h_cnt < 10'(H_ACTIVE + H_FP + H_SYNC)));
	assign vsync_raw = ~((v_cnt >= 10'(V_ACTIVE + V_FP)) &&
		(v_cnt < 10'(V_ACTIVE + V_FP + V_SYNC)));

	assign vid.h_addr = h_cnt;
	assign vid.v_addr = v_cnt;
	assign vid.active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));

	// one cycle delay to meet the registered pixel from the renderer
	always_ff @(posedge clk) begin
		if (rst) begin
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			hsync   <= hsync_raw;
			vsync   <= vsync_raw;
			blank_n <= vid.active;
		end
	end

	// white background, black glyph, dark during blanking
	assign level = (blank_n && !vid.pixel_black) ? 8'hff : 8'h00;
	assign vga_r = level;
	assign vga_g = level;
	assign vga_b = level;

endmodule

//--- key_tracker.sv
`timescale 1ns/1ps

module key_tracker import kbd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	kbd_byte_if.sink    bus,
	output scan_t       last_code,
	output logic        held,
	output logic [7:0]  releases
);

	logic next_r;
	logic pending_break;
	logic pop;

	assign bus.next = next_r;
	assign pop      = next_r & bus.ready;

	// next goes low after every pop, so one byte per two cycles
	always_ff @(posedge clk) begin
		if (rst)
			next_r <= 1'b0;
		else
			next_r <= bus.ready & ~next_r;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending_break <= 1'b0;
			last_code     <= '0;
			held          <= 1'b0;
			releases      <= '0;
		end else if (pop) begin
			if (bus.data == SC_BREAK) begin
				pending_break <= 1'b1;
			end else if (pending_break) begin
				// released key code itself is not kept
				pending_break <= 1'b0;
				held          <= 1'b0;
				releases      <= releases + 8'd1;
			end else begin
				last_code <= bus.data;
				held      <= 1'b1;
			end
		end
	end

endmodule

//--- ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver import kbd_pkg::*; #(
	parameter int FIFO_DEPTH  = 8,
	parameter int IDLE_CYCLES = 2000
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	kbd_byte_if.rx      bus,
	output logic        frame_err,
	output logic [3:0]  level
);

	localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
	localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic              clk_prev;
	logic              clk_fall;
	logic [3:0]        bit_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	ps2_frame_u        frame;
	logic              frame_done;
	logic              frame_ok;

	scan_t             mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  fill;
	logic              full;
	logic              push;
	logic              pop;

	assign clk_fall = clk_prev & ~clk_sync[1];

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame.f.start & frame.f.stop & (^{frame.f.parity, frame.f.data});

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync   <= 2'b11;
			data_sync  <= 2'b11;
			clk_prev   <= 1'b1;
			bit_cnt    <= '0;
			idle_cnt   <= '0;
			frame_done <= 1'b0;
		end else begin
			clk_sync   <= {clk_sync[0], ps2_clk};
			data_sync  <= {data_sync[0], ps2_data};
			clk_prev   <= clk_sync[1];
			frame_done <= 1'b0;
			if (clk_fall) begin
				frame.raw <= {data_sync[1], frame.raw[10:1]};
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			// line held high long enough, drop any partial frame
			if (!clk_sync[1]) begin
				idle_cnt <= '0;
			end else if (idle_cnt == IDLE_W'(IDLE_CYCLES - 1)) begin
				bit_cnt <= '0;
			end else begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	assign full = (fill == CNT_W'(FIFO_DEPTH));
	assign push = frame_done & frame_ok & ~full;
	assign pop  = bus.next & bus.ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= frame.f.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			fill         <= '0;
			frame_err    <= 1'b0;
			bus.overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// both flags sticky until reset
			if (frame_done && !frame_ok)
				frame_err <= 1'b1;
			if (frame_done && frame_ok && full)
				bus.overflow <= 1'b1;
		end
	end

	assign bus.ready = (fill != '0);
	assign bus.data  = mem[rd_ptr];
	assign level     = 4'(fill);

endmodule

//--- video_if.sv
`timescale 1ns/1ps

interface video_if ();
	logic [9:0] h_addr;
	logic [9:0] v_addr;
	logic       active;
	// renderer answer, one cycle behind the coordinates
	logic       pixel_black;

	modport timing (
		output h_addr, v_addr, active,
		input  pixel_black
	);

	modport render (
		input  h_addr, v_addr, active,
		output pixel_black
	);
endinterface

//--- kbd_byte_if.sv
`timescale 1ns/1ps

interface kbd_byte_if import kbd_pkg::*; ();
	scan_t data;
	logic  ready;
	logic  next;
	logic  overflow;

	// head byte pops on any edge where next and ready are both high
	modport rx (
		output data, ready, overflow,
		input  next
	);

	modport sink (
		input  data, ready, overflow,
		output next
	);
endinterface

//--- kbd_pkg.sv
package kbd_pkg;

	typedef logic [7:0] scan_t;

	// ps2 frame arrives lsb first, so start ends up in bit 0
	typedef struct packed {
		logic  stop;
		logic  parity;
		scan_t data;
		logic  start;
	} ps2_fields_t;

	typedef union packed {
		logic [10:0] raw;
		ps2_fields_t f;
	} ps2_frame_u;

	localparam scan_t SC_BREAK = 8'hf0;
	localparam scan_t SC_Q     = 8'h15;
	localparam scan_t SC_D     = 8'h23;

	// 8x16 glyphs, bit 7 is the leftmost pixel
	localparam logic [7:0] GLYPH_Q [16] = '{
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h76, 8'hcc, 8'hcc,
		8'hcc, 8'hcc, 8'hcc, 8'h7c, 8'h0c, 8'h0c, 8'h1e, 8'h00
	};
	localparam logic [7:0] GLYPH_D [16] = '{
		8'h00, 8'h00, 8'h1c, 8'h0c, 8'h0c, 8'h3c, 8'h6c, 8'hcc,
		8'hcc, 8'hcc, 8'hcc, 8'h76, 8'h00, 8'h00, 8'h00, 8'h00
	};

	// segments a..g then dp, active high
	localparam logic [7:0] SEG_TABLE [16] = '{
		8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
		8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
	};

	function automatic logic [7:0] glyph_row(scan_t code, logic [3:0] row);
		if (code == SC_Q)
			return GLYPH_Q[row];
		else if (code == SC_D)
			return GLYPH_D[row];
		return 8'h00;
	endfunction

	function automatic logic [7:0] seg_of_hex(logic [3:0] hex);
		return SEG_TABLE[hex];
	endfunction

endpackage
